// File: hw/kernel_ctrl_pkg.sv
/* Register map and sizes shared by the kernel control wrapper. Only the low 8 bits
   of the host byte address are decoded; word accesses are assumed throughout. */
`default_nettype none

package kernel_ctrl_pkg;

  // Host control bus.
  localparam int SLAVE_ADDR_WIDTH = 16;
  localparam int REG_ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Control registers end here, parameter words fill the rest of the window.
  localparam logic [REG_ADDR_WIDTH-1:0] CTRL_REG_LIMIT = 8'h3F;
  localparam int PARAM_WORDS = 48;
  localparam int PARAM_INDEX_WIDTH = 6;

  // Control register byte addresses.
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_AP_CTRL = 8'h00;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_GIE = 8'h04;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_IER = 8'h08;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_ISR = 8'h0C;

  // Bits of the ap_ctrl register.
  localparam int AP_START_BIT = 0;
  localparam int AP_DONE_BIT = 1;
  localparam int AP_IDLE_BIT = 2;

  // Kernel reset pulse length in clock cycles.
  localparam int KERNEL_RESET_CYCLES = 4;

  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: hw/ctrl_axi_slave.sv
/* AXI4-Lite control slave serving one access at a time, reads ahead of writes.
   Every access gets OKAY; addresses outside the register window fold onto an unused word. */
`default_nettype none

module ctrl_axi_slave (
  input  logic                                    ap_clk,
  input  logic                                    rst,
  input  logic [kernel_ctrl_pkg::SLAVE_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  logic                                    s_axi_awvalid,
  output logic                                    s_axi_awready,
  input  logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]  s_axi_wdata,
  input  logic [kernel_ctrl_pkg::STRB_WIDTH-1:0]  s_axi_wstrb,
  input  logic                                    s_axi_wvalid,
  output logic                                    s_axi_wready,
  output logic [1:0]                              s_axi_bresp,
  output logic                                    s_axi_bvalid,
  input  logic                                    s_axi_bready,
  input  logic [kernel_ctrl_pkg::SLAVE_ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic                                    s_axi_arvalid,
  output logic                                    s_axi_arready,
  output logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]  s_axi_rdata,
  output logic [1:0]                              s_axi_rresp,
  output logic                                    s_axi_rvalid,
  input  logic                                    s_axi_rready,
  output logic                                    reg_req,
  output logic                                    reg_write_en,
  output logic [kernel_ctrl_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  output logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]  reg_wdata,
  output logic [kernel_ctrl_pkg::STRB_WIDTH-1:0]  reg_wstrb,
  input  logic                                    reg_ack,
  input  logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]  reg_rdata
);
  import kernel_ctrl_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_ACK,
    RESP
  } state_t;

  state_t state;
  logic is_read;
  logic ar_take;
  logic aw_take;
  logic [SLAVE_ADDR_WIDTH-1:0] take_addr;
  logic [DATA_WIDTH-1:0] rdata_q;

  // A pending read wins over a pending write.
  assign ar_take = (state == IDLE) && s_axi_arvalid;
  assign aw_take = (state == IDLE) && s_axi_awvalid && s_axi_wvalid && !s_axi_arvalid;

  assign s_axi_arready = ar_take;
  assign s_axi_awready = aw_take;
  assign s_axi_wready = aw_take;
  assign take_addr = ar_take ? s_axi_araddr : s_axi_awaddr;

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      state <= IDLE;
      is_read <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (ar_take || aw_take) begin
            state <= REQ;
            is_read <= ar_take;
          end
        end
        REQ: state <= WAIT_ACK;
        WAIT_ACK: begin
          if (reg_ack) begin
            state <= RESP;
          end
        end
        RESP: begin
          // Hold the response until the host takes it.
          if ((s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready)) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request payload, captured on the address handshake.
  always_ff @(posedge ap_clk) begin
    if (ar_take || aw_take) begin
      reg_wdata <= s_axi_wdata;
      reg_wstrb <= s_axi_wstrb;
      if (take_addr[SLAVE_ADDR_WIDTH-1:REG_ADDR_WIDTH] != '0) begin
        // Last control word is unused, so these read zero.
        reg_addr <= {CTRL_REG_LIMIT[REG_ADDR_WIDTH-1:2], 2'b00};
      end else begin
        reg_addr <= take_addr[REG_ADDR_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (state == WAIT_ACK && reg_ack) begin
      rdata_q <= reg_rdata;
    end
  end

  assign reg_req = (state == REQ);
  assign reg_write_en = !is_read;

  assign s_axi_bvalid = (state == RESP) && !is_read;
  assign s_axi_bresp = RESP_OKAY;
  assign s_axi_rvalid = (state == RESP) && is_read;
  assign s_axi_rresp = RESP_OKAY;
  assign s_axi_rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/kernel_ctrl_reg.sv
/* Control, status and interrupt registers; owns every address outside 0x40-0xFF.
   Only byte lane 0 of a write is used. Unused words read zero and ignore writes. */
`default_nettype none

module kernel_ctrl_reg (
  input  logic                                       ap_clk,
  input  logic                                       rst,
  input  logic                                       reg_req,
  input  logic                                       reg_write_en,
  input  logic [kernel_ctrl_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]     reg_wdata,
  input  logic [kernel_ctrl_pkg::STRB_WIDTH-1:0]     reg_wstrb,
  input  logic                                       done_pulse,
  output logic                                       reg_ack,
  output logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]     reg_rdata,
  output logic                                       start_pulse,
  output logic                                       interrupt
);
  import kernel_ctrl_pkg::*;

  logic owns;
  logic wr;
  logic rd;
  logic start_req;
  logic [REG_ADDR_WIDTH-1:0] word_addr;
  logic [DATA_WIDTH-1:0] rd_value;
  logic ap_start;
  logic ap_done;
  logic ap_idle;
  logic gie;
  logic ier;
  logic isr;

  assign owns = (reg_addr <= CTRL_REG_LIMIT);
  assign word_addr = {reg_addr[REG_ADDR_WIDTH-1:2], 2'b00};
  assign wr = reg_req && reg_write_en && owns && reg_wstrb[0];
  assign rd = reg_req && !reg_write_en && owns;

  // Start is only honoured while the kernel is idle.
  assign start_req = wr && (word_addr == ADDR_AP_CTRL) && reg_wdata[AP_START_BIT] && ap_idle;

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      ap_start <= 1'b0;
      ap_done <= 1'b0;
      ap_idle <= 1'b1;
      gie <= 1'b0;
      ier <= 1'b0;
      isr <= 1'b0;
      start_pulse <= 1'b0;
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= reg_req && owns;
      start_pulse <= start_req;

      if (start_req) begin
        ap_start <= 1'b1;
      end else if (start_pulse) begin
        ap_start <= 1'b0;
      end

      if (start_req) begin
        ap_idle <= 1'b0;
      end else if (done_pulse) begin
        ap_idle <= 1'b1;
      end

      // Done is cleared by reading it, unless a new done arrives.
      if (done_pulse) begin
        ap_done <= 1'b1;
      end else if (rd && word_addr == ADDR_AP_CTRL) begin
        ap_done <= 1'b0;
      end

      if (wr && word_addr == ADDR_GIE) begin
        gie <= reg_wdata[0];
      end
      if (wr && word_addr == ADDR_IER) begin
        ier <= reg_wdata[0];
      end

      // ISR bit toggles on a write of one.
      if (done_pulse && ier) begin
        isr <= 1'b1;
      end else if (wr && word_addr == ADDR_ISR && reg_wdata[0]) begin
        isr <= !isr;
      end
    end
  end

  always_comb begin
    rd_value = '0;
    case (word_addr)
      ADDR_AP_CTRL: begin
        rd_value[AP_START_BIT] = ap_start;
        rd_value[AP_DONE_BIT] = ap_done;
        rd_value[AP_IDLE_BIT] = ap_idle;
      end
      ADDR_GIE: rd_value[0] = gie;
      ADDR_IER: rd_value[0] = ier;
      ADDR_ISR: rd_value[0] = isr;
      default: rd_value = '0;
    endcase
  end

  // Zero unless this block answers a read, so the top level can OR it in.
  always_ff @(posedge ap_clk) begin
    reg_rdata <= rd ? rd_value : '0;
  end

  assign interrupt = gie && ier && isr;

endmodule

`default_nettype wire

// File: hw/kernel_param_mem.sv
/* Parameter words at byte addresses 0x40-0xFF, written by the host with byte strobes.
   The kernel reads by word index; one read in flight, indexes past the end return zero. */
`default_nettype none

module kernel_param_mem (
  input  logic                                       ap_clk,
  input  logic                                       rst,
  input  logic                                       reg_req,
  input  logic                                       reg_write_en,
  input  logic [kernel_ctrl_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]     reg_wdata,
  input  logic [kernel_ctrl_pkg::STRB_WIDTH-1:0]     reg_wstrb,
  output logic                                       reg_ack,
  output logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]     reg_rdata,
  input  logic                                       param_addr_valid,
  input  logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]     param_addr,
  output logic                                       param_addr_stop,
  output logic                                       param_data_valid,
  output logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]     param_data,
  input  logic                                       param_data_stop
);
  import kernel_ctrl_pkg::*;

  logic [DATA_WIDTH-1:0] mem [PARAM_WORDS];
  logic owns;
  logic host_wr;
  logic host_rd;
  logic [PARAM_INDEX_WIDTH-1:0] host_index;
  logic addr_take;
  logic addr_in_range;

  assign owns = (reg_addr > CTRL_REG_LIMIT);
  assign host_wr = reg_req && reg_write_en && owns;
  assign host_rd = reg_req && !reg_write_en && owns;

  // Word index relative to the first parameter word at 0x40.
  assign host_index = reg_addr[REG_ADDR_WIDTH-1:2] - CTRL_REG_LIMIT[REG_ADDR_WIDTH-1:2] - 1'b1;

  always_ff @(posedge ap_clk) begin
    if (host_wr) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (reg_wstrb[b]) begin
          mem[host_index][8*b +: 8] <= reg_wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= reg_req && owns;
    end
  end

  always_ff @(posedge ap_clk) begin
    reg_rdata <= host_rd ? mem[host_index] : '0;
  end

  // Kernel side. A waiting data word blocks the next address.
  assign param_addr_stop = param_data_valid;
  assign addr_take = param_addr_valid && !param_addr_stop;
  assign addr_in_range = (param_addr < DATA_WIDTH'(PARAM_WORDS));

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      param_data_valid <= 1'b0;
    end else if (addr_take) begin
      param_data_valid <= 1'b1;
    end else if (!param_data_stop) begin
      param_data_valid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (addr_take) begin
      param_data <= addr_in_range ? mem[param_addr[PARAM_INDEX_WIDTH-1:0]] : '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/kernel_reset_handler.sv
/* Resets the kernel for KERNEL_RESET_CYCLES on each start, then offers go until taken.
   Starts that arrive while a sequence is running are ignored. */
`default_nettype none

module kernel_reset_handler (
  input  logic ap_clk,
  input  logic rst,
  input  logic start_pulse,
  input  logic go_stop,
  input  logic done_valid,
  output logic kernel_reset,
  output logic go_valid,
  output logic done_stop,
  output logic done_pulse
);
  import kernel_ctrl_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RESET,
    SETTLE,
    GO
  } state_t;

  state_t state;
  logic [$clog2(KERNEL_RESET_CYCLES)-1:0] count;

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      state <= IDLE;
      count <= '0;
      done_pulse <= 1'b0;
    end else begin
      // Done is only accepted while the kernel is out of reset.
      done_pulse <= done_valid && !done_stop;
      case (state)
        IDLE: begin
          if (start_pulse) begin
            state <= RESET;
            count <= ($clog2(KERNEL_RESET_CYCLES))'(KERNEL_RESET_CYCLES - 1);
          end
        end
        RESET: begin
          if (count == '0) begin
            state <= SETTLE;
          end else begin
            count <= count - 1'b1;
          end
        end
        // One quiet cycle after reset falls before go is offered.
        SETTLE: state <= GO;
        GO: begin
          if (!go_stop) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign kernel_reset = (state == RESET);
  assign go_valid = (state == GO);
  assign done_stop = kernel_reset;

endmodule

`default_nettype wire

// File: hw/kernel_wrapper.sv
/* Control half of the kernel wrapper with the kernel left outside at the ports.
   Strobes transfer on cycles where valid is high and stop is low. */
`default_nettype none

module kernel_wrapper (
  input  logic                                         ap_clk,
  input  logic                                         rst,
  input  logic [kernel_ctrl_pkg::SLAVE_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  logic                                         s_axi_awvalid,
  output logic                                         s_axi_awready,
  input  logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]       s_axi_wdata,
  input  logic [kernel_ctrl_pkg::STRB_WIDTH-1:0]       s_axi_wstrb,
  input  logic                                         s_axi_wvalid,
  output logic                                         s_axi_wready,
  output logic [1:0]                                   s_axi_bresp,
  output logic                                         s_axi_bvalid,
  input  logic                                         s_axi_bready,
  input  logic [kernel_ctrl_pkg::SLAVE_ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic                                         s_axi_arvalid,
  output logic                                         s_axi_arready,
  output logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]       s_axi_rdata,
  output logic [1:0]                                   s_axi_rresp,
  output logic                                         s_axi_rvalid,
  input  logic                                         s_axi_rready,
  output logic                                         kernel_reset,
  output logic                                         go_valid,
  input  logic                                         go_stop,
  input  logic                                         done_valid,
  output logic                                         done_stop,
  input  logic                                         param_addr_valid,
  input  logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]       param_addr,
  output logic                                         param_addr_stop,
  output logic                                         param_data_valid,
  output logic [kernel_ctrl_pkg::DATA_WIDTH-1:0]       param_data,
  input  logic                                         param_data_stop,
  output logic                                         interrupt
);
  import kernel_ctrl_pkg::*;

  logic reg_req;
  logic reg_write_en;
  logic [REG_ADDR_WIDTH-1:0] reg_addr;
  logic [DATA_WIDTH-1:0] reg_wdata;
  logic [STRB_WIDTH-1:0] reg_wstrb;
  logic reg_ack;
  logic reg_ack_ctrl;
  logic reg_ack_param;
  logic [DATA_WIDTH-1:0] reg_rdata;
  logic [DATA_WIDTH-1:0] reg_rdata_ctrl;
  logic [DATA_WIDTH-1:0] reg_rdata_param;
  logic start_pulse;
  logic done_pulse;

  ctrl_axi_slave u_ctrl_axi_slave (.*);

  kernel_ctrl_reg u_kernel_ctrl_reg (
    .*,
    .reg_ack(reg_ack_ctrl),
    .reg_rdata(reg_rdata_ctrl)
  );

  kernel_param_mem u_kernel_param_mem (
    .*,
    .reg_ack(reg_ack_param),
    .reg_rdata(reg_rdata_param)
  );

  kernel_reset_handler u_kernel_reset_handler (.*);

  // Non-owning stages answer with zero, so a plain OR merges them.
  assign reg_ack = reg_ack_ctrl | reg_ack_param;
  assign reg_rdata = reg_rdata_ctrl | reg_rdata_param;

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
/* Free running clock with a period of 40 time units. Reset is high for the first two edges. */
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

  always #20 clk = ~clk;

endmodule

`default_nettype wire

// File: tests/kernel_wrapper_asserts.sv
/* Protocol checks on the AXI4-Lite slave and its register request, bound into ctrl_axi_slave.
   fail_count holds the number of assertion failures seen so far. */
`default_nettype none

module kernel_wrapper_asserts (
  input logic                                   ap_clk,
  input logic                                   rst,
  input logic                                   s_axi_awready,
  input logic                                   s_axi_arready,
  input logic                                   s_axi_bvalid,
  input logic                                   s_axi_bready,
  input logic                                   s_axi_rvalid,
  input logic                                   s_axi_rready,
  input logic [kernel_ctrl_pkg::DATA_WIDTH-1:0] s_axi_rdata,
  input logic                                   reg_req,
  input logic                                   reg_ack
);

  int fail_count = 0;
  logic pending;

  // An accepted access stays open until its response is taken.
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (s_axi_arready || s_axi_awready) begin
      pending <= 1'b1;
    end else if ((s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready)) begin
      pending <= 1'b0;
    end
  end

  // Responses stay up until the host takes them.
  bvalid_hold: assert property (@(posedge ap_clk) disable iff (rst)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  rvalid_hold: assert property (@(posedge ap_clk) disable iff (rst)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else begin
      $error("rvalid or rdata changed before rready");
      fail_count++;
    end

  ack_follows_req: assert property (@(posedge ap_clk) disable iff (rst)
      reg_req |=> reg_ack)
    else begin
      $error("reg_ack missing one cycle after reg_req");
      fail_count++;
    end

  // Nothing new is accepted while an earlier access is still open.
  single_access: assert property (@(posedge ap_clk) disable iff (rst)
      pending |-> !(s_axi_arready || s_axi_awready))
    else begin
      $error("address accepted while an access was pending");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: tests/kernel_wrapper_tb.sv
/* Testbench acting as the host on the control bus and as the kernel at the strobe ports.
   Kernel stop inputs and the host ready signals are random with a fixed seed. */
`default_nettype none

module kernel_wrapper_tb;
  import kernel_ctrl_pkg::*;

  typedef struct packed {
    logic                        is_write;
    logic [SLAVE_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]       wdata;
    logic [STRB_WIDTH-1:0]       wstrb;
    logic [DATA_WIDTH-1:0]       rdata;
  } host_op_t;

  localparam int TABLE_LEN = 18;
  localparam int TIMEOUT_CYCLES = TABLE_LEN * 20 + 500;
  localparam logic [DATA_WIDTH-1:0] IDLE_ONLY = 32'h1 << AP_IDLE_BIT;
  localparam logic [DATA_WIDTH-1:0] DONE_IDLE = (32'h1 << AP_DONE_BIT) | IDLE_ONLY;

  logic ap_clk, rst;
  logic [SLAVE_ADDR_WIDTH-1:0] s_axi_awaddr, s_axi_araddr;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
  logic [DATA_WIDTH-1:0] s_axi_wdata, s_axi_rdata;
  logic [STRB_WIDTH-1:0] s_axi_wstrb;
  logic [1:0] s_axi_bresp, s_axi_rresp;
  logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
  logic kernel_reset, go_valid, go_stop, done_valid, done_stop, interrupt;
  logic param_addr_valid, param_addr_stop, param_data_valid, param_data_stop;
  logic [DATA_WIDTH-1:0] param_addr, param_data;

  host_op_t ops [TABLE_LEN];
  integer seed = 7;
  int cycle_count = 0;

  tb_clock_gen clock_gen (.clk(ap_clk), .rst(rst));

  kernel_wrapper UUT (.*);

  bind ctrl_axi_slave kernel_wrapper_asserts u_asserts (.*);

  function automatic logic coin_flip();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic fail_now();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                             input logic [DATA_WIDTH-1:0] expected);
    assert (actual === expected) else begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      fail_now();
    end
  endtask

  task automatic host_write(input logic [SLAVE_ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data,
                            input logic [STRB_WIDTH-1:0] strb);
    int latency;
    s_axi_awaddr <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata <= data;
    s_axi_wstrb <= strb;
    s_axi_wvalid <= 1'b1;
    s_axi_bready <= coin_flip();
    @(posedge ap_clk);
    while (!(s_axi_awready && s_axi_wready)) @(posedge ap_clk);
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid <= 1'b0;
    latency = 1;
    @(posedge ap_clk);
    while (!s_axi_bvalid) begin
      latency++;
      @(posedge ap_clk);
    end
    check_value("write latency", latency, 3);
    // Host holds off for a random number of cycles.
    while (!s_axi_bready) begin
      s_axi_bready <= coin_flip();
      @(posedge ap_clk);
    end
    check_value("s_axi_bresp", s_axi_bresp, RESP_OKAY);
    s_axi_bready <= 1'b0;
  endtask

  task automatic host_read(input logic [SLAVE_ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] expected);
    int latency;
    s_axi_araddr <= addr;
    s_axi_arvalid <= 1'b1;
    @(posedge ap_clk);
    while (!s_axi_arready) @(posedge ap_clk);
    s_axi_arvalid <= 1'b0;
    s_axi_rready <= coin_flip();
    latency = 1;
    @(posedge ap_clk);
    while (!s_axi_rvalid) begin
      latency++;
      @(posedge ap_clk);
    end
    check_value("read latency", latency, 3);
    // Host holds off for a random number of cycles.
    while (!s_axi_rready) begin
      s_axi_rready <= coin_flip();
      @(posedge ap_clk);
    end
    check_value("s_axi_rresp", s_axi_rresp, RESP_OKAY);
    check_value("s_axi_rdata", s_axi_rdata, expected);
    s_axi_rready <= 1'b0;
  endtask

  task automatic kernel_read(input int index, input logic [DATA_WIDTH-1:0] expected);
    logic [DATA_WIDTH-1:0] held;
    param_addr <= DATA_WIDTH'(index);
    param_addr_valid <= 1'b1;
    @(posedge ap_clk);
    while (param_addr_stop) @(posedge ap_clk);
    param_addr_valid <= 1'b0;
    @(posedge ap_clk);
    check_value("param_data_valid", param_data_valid, 1);
    // A waiting data word blocks the next address.
    check_value("param_addr_stop", param_addr_stop, 1);
    held = param_data;
    while (param_data_stop) begin
      param_data_stop <= coin_flip();
      @(posedge ap_clk);
      check_value("param_data_valid", param_data_valid, 1);
      check_value("param_data", param_data, held);
    end
    check_value("param_data", held, expected);
    param_data_stop <= coin_flip();
    @(posedge ap_clk);
    // A repeated word would still be valid here.
    check_value("param_data_valid", param_data_valid, 0);
  endtask

  task automatic watch_start();
    int reset_cycles;
    reset_cycles = 0;
    @(posedge ap_clk);
    while (!kernel_reset) @(posedge ap_clk);
    while (kernel_reset) begin
      check_value("done_stop", done_stop, 1);
      reset_cycles++;
      go_stop <= coin_flip();
      @(posedge ap_clk);
    end
    check_value("kernel_reset cycles", reset_cycles, KERNEL_RESET_CYCLES);
    while (!go_valid) begin
      go_stop <= coin_flip();
      @(posedge ap_clk);
    end
    // Go must stay up until the kernel drops go_stop.
    while (go_stop) begin
      go_stop <= coin_flip();
      @(posedge ap_clk);
      check_value("go_valid", go_valid, 1);
    end
    go_stop <= 1'b1;
    @(posedge ap_clk);
    check_value("go_valid", go_valid, 0);
  endtask

  task automatic finish_kernel();
    done_valid <= 1'b1;
    @(posedge ap_clk);
    while (done_stop) @(posedge ap_clk);
    done_valid <= 1'b0;
  endtask

  task automatic run_kernel();
    fork
      host_write(ADDR_AP_CTRL, 32'h1 << AP_START_BIT, 4'hF);
      watch_start();
    join
    // Kernel is busy, so start, done and idle all read 0.
    host_read(ADDR_AP_CTRL, 32'h0);
    finish_kernel();
  endtask

  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped answering.", cycle_count);
      fail_now();
    end else if (UUT.u_ctrl_axi_slave.u_asserts.fail_count != 0) begin
      $display("A bound assertion on the AXI slave failed.");
      fail_now();
    end
  end

  initial begin
    s_axi_awaddr = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_wstrb = '0;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b0;
    s_axi_araddr = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b0;
    go_stop = 1'b1;
    done_valid = 1'b0;
    param_addr_valid = 1'b0;
    param_addr = '0;
    param_data_stop = 1'b0;

    // Kind, address, write data, strobes, expected read data.
    ops[0] = '{1'b1, 16'h0040, 32'hCAFE0000, 4'hF, 32'h0};
    ops[1] = '{1'b1, 16'h0044, 32'h11223344, 4'hF, 32'h0};
    ops[2] = '{1'b1, 16'h0048, 32'hDEADBEEF, 4'hF, 32'h0};
    ops[3] = '{1'b1, 16'h004C, 32'h0BADF00D, 4'hF, 32'h0};
    ops[4] = '{1'b1, 16'h00FC, 32'h5A5A5A5A, 4'hF, 32'h0};
    ops[5] = '{1'b1, 16'h0044, 32'hAABBCCDD, 4'h5, 32'h0};
    ops[6] = '{1'b1, 16'h0140, 32'h12345678, 4'hF, 32'h0};
    ops[7] = '{1'b1, 16'h0020, 32'hFFFFFFFF, 4'hF, 32'h0};
    ops[8] = '{1'b0, 16'h0040, 32'h0, 4'h0, 32'hCAFE0000};
    ops[9] = '{1'b0, 16'h0044, 32'h0, 4'h0, 32'h11BB33DD};
    ops[10] = '{1'b0, 16'h0048, 32'h0, 4'h0, 32'hDEADBEEF};
    ops[11] = '{1'b0, 16'h004C, 32'h0, 4'h0, 32'h0BADF00D};
    ops[12] = '{1'b0, 16'h00FC, 32'h0, 4'h0, 32'h5A5A5A5A};
    ops[13] = '{1'b0, 16'h0100, 32'h0, 4'h0, 32'h0};
    ops[14] = '{1'b0, 16'h1040, 32'h0, 4'h0, 32'h0};
    ops[15] = '{1'b0, 16'h0020, 32'h0, 4'h0, 32'h0};
    ops[16] = '{1'b0, 16'h003C, 32'h0, 4'h0, 32'h0};
    ops[17] = '{1'b0, 16'h0010, 32'h0, 4'h0, 32'h0};

    @(posedge ap_clk);
    while (rst) @(posedge ap_clk);
    check_value("interrupt", interrupt, 0);
    check_value("go_valid", go_valid, 0);
    check_value("kernel_reset", kernel_reset, 0);
    check_value("s_axi_bvalid", s_axi_bvalid, 0);
    check_value("s_axi_rvalid", s_axi_rvalid, 0);
    host_read(ADDR_AP_CTRL, IDLE_ONLY);

    for (int i = 0; i < TABLE_LEN; i++) begin
      if (ops[i].is_write) begin
        host_write(ops[i].addr, ops[i].wdata, ops[i].wstrb);
      end else begin
        host_read(ops[i].addr, ops[i].rdata);
      end
    end

    // Kernel index i reads byte address 0x40 + 4 * i.
    kernel_read(0, 32'hCAFE0000);
    kernel_read(1, 32'h11BB33DD);
    kernel_read(2, 32'hDEADBEEF);
    kernel_read(3, 32'h0BADF00D);
    kernel_read(47, 32'h5A5A5A5A);
    kernel_read(48, 32'h0);
    kernel_read(200, 32'h0);

    // First run with only GIE set.
    host_write(ADDR_GIE, 32'h1, 4'hF);
    run_kernel();
    host_read(ADDR_AP_CTRL, DONE_IDLE);
    host_read(ADDR_AP_CTRL, IDLE_ONLY);
    host_read(ADDR_ISR, 32'h0);
    check_value("interrupt", interrupt, 0);

    // Second run with only IER set, GIE enabled afterwards.
    host_write(ADDR_GIE, 32'h0, 4'hF);
    host_write(ADDR_IER, 32'h1, 4'hF);
    run_kernel();
    host_read(ADDR_ISR, 32'h1);
    check_value("interrupt", interrupt, 0);
    host_write(ADDR_GIE, 32'h1, 4'hF);
    check_value("interrupt", interrupt, 1);
    host_write(ADDR_ISR, 32'h1, 4'hF);
    check_value("interrupt", interrupt, 0);
    host_read(ADDR_ISR, 32'h0);

    repeat (2) @(posedge ap_clk);
    if (UUT.u_ctrl_axi_slave.u_asserts.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_now();
    end
  end

endmodule

`default_nettype wire

// File: list.f
hw/kernel_ctrl_pkg.sv
hw/ctrl_axi_slave.sv
hw/kernel_ctrl_reg.sv
hw/kernel_param_mem.sv
hw/kernel_reset_handler.sv
hw/kernel_wrapper.sv
tests/tb_clock_gen.sv
tests/kernel_wrapper_asserts.sv
tests/kernel_wrapper_tb.sv

// File: Bender.yml
package:
  name: kernel_wrapper

sources:
  - hw/kernel_ctrl_pkg.sv
  - hw/ctrl_axi_slave.sv
  - hw/kernel_ctrl_reg.sv
  - hw/kernel_param_mem.sv
  - hw/kernel_reset_handler.sv
  - hw/kernel_wrapper.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/kernel_wrapper_asserts.sv
      - tests/kernel_wrapper_tb.sv
